// ==== vlog.f ====
rtl/exu_pkg.sv
rtl/exu_if.sv
rtl/issue_stage.sv
rtl/alu.sv
rtl/multiplier.sv
rtl/divider.sv
rtl/integer_unit.sv
rtl/exu_top.sv
verif/exu_checker.sv
verif/exu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run with Verilator, the log decides pass or fail
set -o pipefail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module exu_tb -f vlog.f -o exu_sim \
    && ./obj_dir/exu_sim | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }
grep -q "Regression failed" sim.log && exit 1 || exit 0

// ==== verif/exu_tb.sv ====
`default_nettype none

module exu_tb import exu_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int N_ALU        = 48;
    localparam int N_MUL        = 40;
    localparam int N_DIV        = 24;
    // Every division may take the full iteration count plus its gap
    localparam int RUN_CYCLES      = RESET_CYCLES + N_ALU + N_MUL + N_DIV * (DIV_STEPS + 8);
    localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES + 200;

    logic       clk_i;
    logic       rst_i;
    logic       kill_i;
    logic       instr_valid_i;
    exu_op_t    op_i;
    data_word_t operand_a_i;
    data_word_t operand_b_i;
    instr_tag_t tag_i;
    logic       result_valid_o;
    data_word_t result_o;
    instr_tag_t result_tag_o;
    logic       result_trap_o;
    logic       div_idle_o;
    instr_tag_t next_tag;
    int         error_count;
    int         check_count;
    int         pending;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    exu_top dut (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .kill_i         (kill_i),
        .instr_valid_i  (instr_valid_i),
        .op_i           (op_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .tag_i          (tag_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .result_tag_o   (result_tag_o),
        .result_trap_o  (result_trap_o),
        .div_idle_o     (div_idle_o)
    );

    exu_checker u_checker (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .kill_i         (kill_i),
        .instr_valid_i  (instr_valid_i),
        .op_i           (op_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .tag_i          (tag_i),
        .result_valid_i (result_valid_o),
        .result_i       (result_o),
        .result_tag_i   (result_tag_o),
        .result_trap_i  (result_trap_o),
        .div_idle_i     (div_idle_o),
        .error_count_o  (error_count),
        .check_count_o  (check_count),
        .pending_o      (pending)
    );

    // ==================================================
    // Stimulus helpers
    // ==================================================

    // Extreme values show up often enough to hit the corner cases
    function automatic data_word_t pick_operand();
        case ($urandom_range(0, 7))
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            3:       return 32'h7fff_ffff;
            default: return $urandom();
        endcase
    endfunction

    task automatic issue_instr(exu_op_t op, data_word_t a, data_word_t b);
        instr_valid_i <= 1'b1;
        op_i          <= op;
        operand_a_i   <= a;
        operand_b_i   <= b;
        tag_i         <= next_tag;
        next_tag       = next_tag + 1'b1;
        @(posedge clk_i);
    endtask

    task automatic pause(int cycles);
        instr_valid_i <= 1'b0;
        repeat (cycles) @(posedge clk_i);
    endtask

    // The divider is busy until div_idle_o rises again
    task automatic issue_div(exu_op_t op, data_word_t a, data_word_t b);
        issue_instr(op, a, b);
        instr_valid_i <= 1'b0;
        @(negedge clk_i);
        while (!div_idle_o) @(negedge clk_i);
        @(posedge clk_i);
        pause(3);
    endtask

    task automatic kill_cycle();
        instr_valid_i <= 1'b0;
        kill_i        <= 1'b1;
        @(posedge clk_i);
        kill_i        <= 1'b0;
    endtask

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        int unsigned seed;
        data_word_t  divisor;
        seed = 32'hff294074;
        void'($urandom(seed));
        clk_i         = 1'b0;
        rst_i         = 1'b1;
        kill_i        = 1'b0;
        instr_valid_i = 1'b0;
        op_i          = OP_ADD;
        operand_a_i   = '0;
        operand_b_i   = '0;
        tag_i         = '0;
        next_tag      = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
        pause(2);

        // Shifts by 31 and signed against unsigned compares first
        issue_instr(OP_SLL, 32'h8000_0001, 32'd31);
        issue_instr(OP_SRL, 32'h8000_0001, 32'd31);
        issue_instr(OP_SRA, 32'h8000_0001, 32'd31);
        issue_instr(OP_SLT, 32'h8000_0000, 32'd1);
        issue_instr(OP_SLTU, 32'h8000_0000, 32'd1);
        issue_instr(OP_SLT, 32'd1, 32'hffff_ffff);
        repeat (N_ALU - 10) issue_instr(exu_op_t'($urandom_range(0, 9)), pick_operand(),
                                        pick_operand());
        pause(3);

        repeat (N_MUL - 6) issue_instr(exu_op_t'($urandom_range(10, 13)), pick_operand(),
                                       pick_operand());
        pause(3);

        // Signed overflow cases, then random divisions with a nonzero divisor
        issue_div(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
        issue_div(OP_REM, 32'h8000_0000, 32'hffff_ffff);
        issue_div(OP_DIVU, 32'h8000_0000, 32'hffff_ffff);
        issue_div(OP_REMU, 32'hffff_fff9, 32'd7);
        repeat (12) begin
            divisor = pick_operand();
            if (divisor == '0) divisor = 32'd3;
            issue_div(exu_op_t'($urandom_range(14, 17)), pick_operand(), divisor);
        end

        // Zero divisor raises the trap with the RISC-V result
        issue_div(OP_DIV, $urandom(), '0);
        issue_div(OP_DIVU, $urandom(), '0);
        issue_div(OP_REM, $urandom(), '0);
        issue_div(OP_REMU, $urandom(), '0);

        // Kill with multiplies still in the pipeline
        repeat (6) issue_instr(exu_op_t'($urandom_range(10, 13)), pick_operand(),
                               pick_operand());
        kill_cycle();
        pause(3);

        // Kill aborts a running division
        issue_instr(OP_DIVU, $urandom(), 32'd5);
        pause(10);
        kill_cycle();
        pause(3);

        repeat (4) issue_instr(exu_op_t'($urandom_range(0, 9)), pick_operand(), pick_operand());
        pause(3);

        @(negedge clk_i);
        while (pending != 0) @(negedge clk_i);
        repeat (4) @(negedge clk_i);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Stops a hung run well after the longest possible sequence
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, the test sequence did not finish", WATCHDOG_CYCLES);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("Regression failed");
        $finish;
    end

endmodule : exu_tb

`default_nettype wire

// ==== verif/exu_checker.sv ====
`default_nettype none

module exu_checker import exu_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       rst_i,
    input  wire logic       kill_i,
    input  wire logic       instr_valid_i,
    input  wire exu_op_t    op_i,
    input  wire data_word_t operand_a_i,
    input  wire data_word_t operand_b_i,
    input  wire instr_tag_t tag_i,
    input  wire logic       result_valid_i,
    input  wire data_word_t result_i,
    input  wire instr_tag_t result_tag_i,
    input  wire logic       result_trap_i,
    input  wire logic       div_idle_i,
    output int              error_count_o,
    output int              check_count_o,
    output int              pending_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // One outstanding instruction with the cycle its result is due
    typedef struct packed {
        data_word_t  result;
        instr_tag_t  tag;
        logic        trap;
        logic        is_div;
        logic [31:0] due;
    } expect_t;

    expect_t     exp_q[$];
    logic [31:0] cycle       = '0;
    logic        after_reset = 1'b0;
    logic        kill_seen   = 1'b0;
    logic        div_pending = 1'b0;
    int          error_count = 0;
    int          check_count = 0;
    int          pending_cnt = 0;

    assign error_count_o = error_count;
    assign check_count_o = check_count;
    assign pending_o     = pending_cnt;

    // ==================================================
    // Reference model
    // ==================================================

    function automatic logic is_div_op(exu_op_t op);
        return op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    endfunction

    // Result word of one instruction under the RV32IM rules
    function automatic data_word_t ref_result(exu_op_t op, data_word_t a, data_word_t b);
        int          sa;
        int          sb;
        logic [63:0] prod;
        sa = a;
        sb = b;
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_SRA:  return data_word_t'(sa >>> b[4:0]);
            OP_SLT:  return (sa < sb) ? 32'd1 : 32'd0;
            OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            OP_MUL:  return a * b;
            OP_MULH: begin
                prod = longint'(sa) * longint'(sb);
                return prod[63:32];
            end
            OP_MULHSU: begin
                // Only the first operand carries a sign
                prod = longint'(sa) * longint'({32'b0, b});
                return prod[63:32];
            end
            OP_MULHU: begin
                prod = {32'b0, a} * {32'b0, b};
                return prod[63:32];
            end
            OP_DIV: begin
                if (b == '0) return '1;
                // Most negative value over minus one overflows back to the dividend
                if (a == 32'h8000_0000 && b == '1) return a;
                return data_word_t'(sa / sb);
            end
            OP_DIVU: return (b == '0) ? '1 : a / b;
            OP_REM: begin
                if (b == '0) return a;
                if (a == 32'h8000_0000 && b == '1) return '0;
                return data_word_t'(sa % sb);
            end
            OP_REMU: return (b == '0) ? a : a % b;
            default: return '0;
        endcase
    endfunction

    function automatic logic ref_trap(exu_op_t op, data_word_t b);
        return is_div_op(op) && (b == '0);
    endfunction

    // Cycles from acceptance at the top level to the result including the issue register
    function automatic int ref_latency(exu_op_t op, data_word_t b);
        if (op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU}) return MUL_STAGES + 1;
        if (is_div_op(op)) return (b == '0) ? 2 : DIV_STEPS + 2;
        return 1;
    endfunction

    task automatic compare_field(string name, logic [31:0] exp, logic [31:0] act);
        check_count = check_count + 1;
        if (exp !== act) begin
            error_count = error_count + 1;
            $display("error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic report_failure(string msg);
        error_count = error_count + 1;
        $display("At %0d ns %s", $time, msg);
    endtask

    // ==================================================
    // Cycle by cycle comparison
    // ==================================================

    always @(posedge clk_i) begin
        expect_t entry;
        cycle = cycle + 1;
        if (rst_i) begin
            exp_q.delete();
            after_reset = 1'b1;
            div_pending = 1'b0;
            kill_seen   = 1'b0;
        end else begin
            // The first cycle out of reset must look completely idle
            if (after_reset) begin
                compare_field("result_valid_o", 32'(1'b0), 32'(result_valid_i));
                compare_field("result_trap_o", 32'(1'b0), 32'(result_trap_i));
                compare_field("div_idle_o", 32'(1'b1), 32'(div_idle_i));
                after_reset = 1'b0;
            end
            if (kill_seen) begin
                compare_field("div_idle_o", 32'(1'b1), 32'(div_idle_i));
                kill_seen = 1'b0;
            end
            if (div_pending && div_idle_i) begin
                report_failure("div_idle_o went high while a division was in flight");
            end
            if (kill_i) begin
                if (result_valid_i) begin
                    report_failure("a result appeared in a kill cycle");
                end
                exp_q.delete();
                div_pending = 1'b0;
                kill_seen   = 1'b1;
            end else begin
                if (result_valid_i) begin
                    if (exp_q.size() == 0) begin
                        report_failure("a result appeared with no instruction outstanding");
                    end else begin
                        entry = exp_q.pop_front();
                        compare_field("result_o", entry.result, result_i);
                        compare_field("result_tag_o", 32'(entry.tag), 32'(result_tag_i));
                        compare_field("result_trap_o", 32'(entry.trap), 32'(result_trap_i));
                        compare_field("result_valid_o arrival cycle", entry.due, cycle);
                        if (entry.is_div) div_pending = 1'b0;
                    end
                end else if (result_trap_i) begin
                    report_failure("result_trap_o was high without a valid result");
                end
                // A result whose cycle has passed is lost
                if (exp_q.size() != 0 && exp_q[0].due < cycle) begin
                    report_failure("an expected result did not arrive in time");
                    void'(exp_q.pop_front());
                end
                if (instr_valid_i) begin
                    entry.result = ref_result(op_i, operand_a_i, operand_b_i);
                    entry.tag    = tag_i;
                    entry.trap   = ref_trap(op_i, operand_b_i);
                    entry.is_div = is_div_op(op_i);
                    entry.due    = cycle + 32'(ref_latency(op_i, operand_b_i));
                    exp_q.push_back(entry);
                    if (entry.is_div) div_pending = 1'b1;
                end
            end
        end
        pending_cnt = exp_q.size();
    end

endmodule : exu_checker

`default_nettype wire

// ==== rtl/exu_top.sv ====
`default_nettype none

module exu_top import exu_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       rst_i,
    input  wire logic       kill_i,
    input  wire logic       instr_valid_i,
    input  wire exu_op_t    op_i,
    input  wire data_word_t operand_a_i,
    input  wire data_word_t operand_b_i,
    input  wire instr_tag_t tag_i,
    output logic            result_valid_o,
    output data_word_t      result_o,
    output instr_tag_t      result_tag_o,
    output logic            result_trap_o,
    output logic            div_idle_o
);

    issue_if  issue_bus ();
    result_if result_bus ();

    // Instruction register and unit decode
    issue_stage u_issue (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .kill_i        (kill_i),
        .instr_valid_i (instr_valid_i),
        .op_i          (op_i),
        .operand_a_i   (operand_a_i),
        .operand_b_i   (operand_b_i),
        .tag_i         (tag_i),
        .issue_o       (issue_bus)
    );

    // ALU, multiplier and divider with the result merge
    integer_unit u_int (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .kill_i     (kill_i),
        .issue_i    (issue_bus),
        .result_o   (result_bus),
        .div_idle_o (div_idle_o)
    );

    assign result_valid_o = result_bus.valid;
    assign result_o       = result_bus.result;
    assign result_tag_o   = result_bus.tag;
    assign result_trap_o  = result_bus.trap;

endmodule : exu_top

`default_nettype wire

// ==== rtl/integer_unit.sv ====
`default_nettype none

module integer_unit import exu_pkg::*; (
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire logic kill_i,
    issue_if.sink     issue_i,
    result_if.source  result_o,
    output logic      div_idle_o
);

    logic alu_sel;
    logic mul_sel;
    logic div_sel;
    logic issue_live;

    // Nothing issued in the kill cycle may start
    assign issue_live = issue_i.valid & ~kill_i;
    assign alu_sel    = issue_live & (issue_i.unit == UNIT_ALU);
    assign mul_sel    = issue_live & (issue_i.unit == UNIT_MUL);
    assign div_sel    = issue_live & (issue_i.unit == UNIT_DIV);

    // ==================================================
    // Execution units
    // ==================================================

    data_word_t alu_result;
    logic       alu_valid;
    data_word_t mul_result;
    logic       mul_valid;
    data_word_t div_result;
    logic       div_valid;
    logic       div_by_zero;

    alu u_alu (
        .valid_i     (alu_sel),
        .op_i        (issue_i.op),
        .operand_a_i (issue_i.operand_a),
        .operand_b_i (issue_i.operand_b),
        .result_o    (alu_result),
        .valid_o     (alu_valid)
    );

    multiplier u_mul (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .kill_i      (kill_i),
        .valid_i     (mul_sel),
        .op_i        (issue_i.op),
        .operand_a_i (issue_i.operand_a),
        .operand_b_i (issue_i.operand_b),
        .product_o   (mul_result),
        .valid_o     (mul_valid)
    );

    divider u_div (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .kill_i           (kill_i),
        .valid_i          (div_sel),
        .op_i             (issue_i.op),
        .dividend_i       (issue_i.operand_a),
        .divisor_i        (issue_i.operand_b),
        .result_o         (div_result),
        .valid_o          (div_valid),
        .divide_by_zero_o (div_by_zero),
        .idle_o           (div_idle_o)
    );

    // ==================================================
    // Tag tracking
    // ==================================================

    // Tags shift along with the multiplier stages
    instr_tag_t [MUL_STAGES-1:0] mul_tag_q;
    instr_tag_t                  div_tag_q;

    always_ff @(posedge clk_i) begin
        if (kill_i) begin
            mul_tag_q <= '0;
            div_tag_q <= '0;
        end else begin
            mul_tag_q <= {mul_tag_q[MUL_STAGES-2:0], issue_i.tag};
            // Divider handles one operation at a time, so one held tag suffices
            if (div_sel) begin
                div_tag_q <= issue_i.tag;
            end
        end
    end

    // ==================================================
    // Result merge
    // ==================================================

    logic mul_hit;
    logic div_hit;

    // Results finishing in the kill cycle are dropped as well
    assign mul_hit = mul_valid & ~kill_i;
    assign div_hit = div_valid & ~kill_i;

    assign result_o.valid  = alu_valid | mul_hit | div_hit;
    assign result_o.result = alu_result
                           | (mul_hit ? mul_result : '0)
                           | (div_hit ? div_result : '0);
    assign result_o.tag    = (alu_valid ? issue_i.tag : '0)
                           | (mul_hit ? mul_tag_q[MUL_STAGES-1] : '0)
                           | (div_hit ? div_tag_q : '0);
    assign result_o.trap   = div_hit & div_by_zero;

endmodule : integer_unit

`default_nettype wire

// ==== rtl/divider.sv ====
`default_nettype none

module divider import exu_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       rst_i,
    input  wire logic       kill_i,
    input  wire logic       valid_i,
    input  wire exu_op_t    op_i,
    input  wire data_word_t dividend_i,
    input  wire data_word_t divisor_i,
    output data_word_t      result_o,
    output logic            valid_o,
    output logic            divide_by_zero_o,
    output logic            idle_o
);

    div_state_t           state_q;
    logic [DIV_CNT_W-1:0] count_q;

    // Quotient shifts left while the dividend bits move into the remainder
    data_word_t quo_q;
    data_word_t rem_q;
    data_word_t den_q;
    logic       is_rem_q;
    logic       neg_quo_q;
    logic       neg_rem_q;
    logic       dbz_q;

    logic       is_signed;
    logic       a_neg;
    logic       b_neg;
    data_word_t abs_a;
    data_word_t abs_b;
    logic [32:0] shifted;
    logic [33:0] diff;
    logic        fits;

    // ==================================================
    // Operand preparation
    // ==================================================

    assign is_signed = (op_i == OP_DIV) || (op_i == OP_REM);
    assign a_neg     = is_signed & dividend_i[31];
    assign b_neg     = is_signed & divisor_i[31];
    assign abs_a     = a_neg ? -dividend_i : dividend_i;
    assign abs_b     = b_neg ? -divisor_i : divisor_i;

    // Restoring step, subtract only when the divisor fits
    assign shifted = {rem_q, quo_q[31]};
    assign diff    = {1'b0, shifted} - {2'b0, den_q};
    assign fits    = ~diff[33];

    always_ff @(posedge clk_i) begin
        if (rst_i || kill_i) begin
            state_q <= DIV_IDLE;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (valid_i) begin
                        is_rem_q <= (op_i == OP_REM) || (op_i == OP_REMU);
                        count_q  <= '0;
                        if (divisor_i == '0) begin
                            // RISC-V result is all ones or the dividend, no iterations
                            quo_q     <= '1;
                            rem_q     <= dividend_i;
                            neg_quo_q <= 1'b0;
                            neg_rem_q <= 1'b0;
                            dbz_q     <= 1'b1;
                            state_q   <= DIV_DONE;
                        end else begin
                            quo_q     <= abs_a;
                            rem_q     <= '0;
                            den_q     <= abs_b;
                            neg_quo_q <= a_neg ^ b_neg;
                            neg_rem_q <= a_neg;
                            dbz_q     <= 1'b0;
                            state_q   <= DIV_BUSY;
                        end
                    end
                end
                DIV_BUSY: begin
                    quo_q   <= {quo_q[30:0], fits};
                    rem_q   <= fits ? diff[31:0] : shifted[31:0];
                    count_q <= count_q + 1'b1;
                    if (count_q == DIV_CNT_W'(DIV_STEPS - 1)) begin
                        state_q <= DIV_DONE;
                    end
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    // Sign fix, the overflow case wraps to the most negative value by itself
    always_comb begin
        if (is_rem_q) begin
            result_o = neg_rem_q ? -rem_q : rem_q;
        end else begin
            result_o = neg_quo_q ? -quo_q : quo_q;
        end
    end

    assign valid_o          = (state_q == DIV_DONE);
    assign divide_by_zero_o = (state_q == DIV_DONE) & dbz_q;
    // Busy already in the issue cycle so no second division slips in
    assign idle_o           = (state_q == DIV_IDLE) & ~valid_i;

endmodule : divider

`default_nettype wire

// ==== rtl/multiplier.sv ====
`default_nettype none

module multiplier import exu_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       rst_i,
    input  wire logic       kill_i,
    input  wire logic       valid_i,
    input  wire exu_op_t    op_i,
    input  wire data_word_t operand_a_i,
    input  wire data_word_t operand_b_i,
    output data_word_t      product_o,
    output logic            valid_o
);

    // One valid bit per pipeline stage
    logic [MUL_STAGES-1:0] valid_q;

    logic               a_signed;
    logic               b_signed;
    logic signed [32:0] a_ext_q;
    logic signed [32:0] b_ext_q;
    exu_op_t            op_q;
    logic signed [65:0] full_product;
    data_word_t         product_q;

    // ==================================================
    // Stage one: operand extension
    // ==================================================

    // MULH treats both operands as signed, MULHSU only the first one
    assign a_signed = (op_i == OP_MULH) || (op_i == OP_MULHSU);
    assign b_signed = (op_i == OP_MULH);

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            a_ext_q <= {a_signed & operand_a_i[31], operand_a_i};
            b_ext_q <= {b_signed & operand_b_i[31], operand_b_i};
            op_q    <= op_i;
        end
    end

    // ==================================================
    // Stage two: product and half select
    // ==================================================

    // A 33 by 33 signed product covers every signedness mix
    assign full_product = a_ext_q * b_ext_q;

    always_ff @(posedge clk_i) begin
        if (valid_q[0]) begin
            // Plain MUL returns the low word, the high variants the upper word
            product_q <= (op_q == OP_MUL) ? full_product[31:0] : full_product[63:32];
        end
    end

    // Kill drops every product that is still in flight
    always_ff @(posedge clk_i) begin
        if (rst_i || kill_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[MUL_STAGES-2:0], valid_i};
        end
    end

    assign product_o = product_q;
    assign valid_o   = valid_q[MUL_STAGES-1];

endmodule : multiplier

`default_nettype wire

// ==== rtl/alu.sv ====
`default_nettype none

module alu import exu_pkg::*; (
    input  wire logic       valid_i,
    input  wire exu_op_t    op_i,
    input  wire data_word_t operand_a_i,
    input  wire data_word_t operand_b_i,
    output data_word_t      result_o,
    output logic            valid_o
);

    logic [4:0] shamt;
    data_word_t alu_result;

    // RV32I shifts only use the low five bits of the second operand
    assign shamt = operand_b_i[4:0];

    always_comb begin
        case (op_i)
            OP_ADD:  alu_result = operand_a_i + operand_b_i;
            OP_SUB:  alu_result = operand_a_i - operand_b_i;
            OP_AND:  alu_result = operand_a_i & operand_b_i;
            OP_OR:   alu_result = operand_a_i | operand_b_i;
            OP_XOR:  alu_result = operand_a_i ^ operand_b_i;
            OP_SLL:  alu_result = operand_a_i << shamt;
            OP_SRL:  alu_result = operand_a_i >> shamt;
            // Arithmetic shift keeps the sign bit of operand A
            OP_SRA:  alu_result = data_word_t'($signed(operand_a_i) >>> shamt);
            OP_SLT: begin
                alu_result = {31'b0, $signed(operand_a_i) < $signed(operand_b_i)};
            end
            OP_SLTU: begin
                alu_result = {31'b0, operand_a_i < operand_b_i};
            end
            // Multiply and divide operations never select the ALU
            default: alu_result = '0;
        endcase
    end

    // Zero when not selected so the result merge can be a plain OR
    assign result_o = valid_i ? alu_result : '0;
    assign valid_o  = valid_i;

endmodule : alu

`default_nettype wire

// ==== rtl/issue_stage.sv ====
`default_nettype none

module issue_stage import exu_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       rst_i,
    input  wire logic       kill_i,
    input  wire logic       instr_valid_i,
    input  wire exu_op_t    op_i,
    input  wire data_word_t operand_a_i,
    input  wire data_word_t operand_b_i,
    input  wire instr_tag_t tag_i,
    issue_if.source         issue_o
);

    logic       valid_q;
    unit_sel_t  unit_q;
    unit_sel_t  unit_dec;
    exu_op_t    op_q;
    data_word_t operand_a_q;
    data_word_t operand_b_q;
    instr_tag_t tag_q;

    // Decode the unit class here so each unit only looks at its own valid
    always_comb begin
        case (op_i)
            OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU: unit_dec = UNIT_MUL;
            OP_DIV, OP_DIVU, OP_REM, OP_REMU:     unit_dec = UNIT_DIV;
            default:                              unit_dec = UNIT_ALU;
        endcase
    end

    // A killed instruction never reaches the units
    always_ff @(posedge clk_i) begin
        if (rst_i || kill_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= instr_valid_i;
        end
    end

    // Payload is captured only with a new instruction
    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            unit_q      <= unit_dec;
            op_q        <= op_i;
            operand_a_q <= operand_a_i;
            operand_b_q <= operand_b_i;
            tag_q       <= tag_i;
        end
    end

    assign issue_o.valid     = valid_q;
    assign issue_o.unit      = unit_q;
    assign issue_o.op        = op_q;
    assign issue_o.operand_a = operand_a_q;
    assign issue_o.operand_b = operand_b_q;
    assign issue_o.tag       = tag_q;

endmodule : issue_stage

`default_nettype wire

// ==== rtl/exu_if.sv ====
`default_nettype none

// One instruction leaving the issue register towards the units
interface issue_if import exu_pkg::*; ();
    logic       valid;
    unit_sel_t  unit;
    exu_op_t    op;
    data_word_t operand_a;
    data_word_t operand_b;
    instr_tag_t tag;

    modport source (output valid, unit, op, operand_a, operand_b, tag);
    modport sink   (input  valid, unit, op, operand_a, operand_b, tag);
endinterface : issue_if

// Merged result of all units, every field is zero while valid is low
interface result_if import exu_pkg::*; ();
    logic       valid;
    data_word_t result;
    instr_tag_t tag;
    logic       trap;

    modport source (output valid, result, tag, trap);
    modport sink   (input  valid, result, tag, trap);
endinterface : result_if

`default_nettype wire

// ==== rtl/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

    // ==================================================
    // Data widths
    // ==================================================

    // Operand and result word of the RV32 datapath
    typedef logic [31:0] data_word_t;

    // Identifier that follows each instruction to its result
    typedef logic [5:0] instr_tag_t;

    // ==================================================
    // Operation encodings
    // ==================================================

    // Operations are grouped by the unit that executes them
    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_MUL,
        OP_MULH,
        OP_MULHSU,
        OP_MULHU,
        OP_DIV,
        OP_DIVU,
        OP_REM,
        OP_REMU
    } exu_op_t;

    // Unit class chosen by the issue stage decoder
    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_MUL,
        UNIT_DIV
    } unit_sel_t;

    // ==================================================
    // Latencies and divider control
    // ==================================================

    // Depth of the multiplier pipeline in cycles
    localparam int MUL_STAGES = 2;

    // One quotient bit is produced per divider iteration
    localparam int DIV_STEPS = 32;
    localparam int DIV_CNT_W = $clog2(DIV_STEPS);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_t;

endpackage : exu_pkg

`default_nettype wire
